//--- Bender.yml
package:
  name: cache

sources:
  - cache_pkg.sv
  - cache_lookup_if.sv
  - cache_ways.sv
  - cache_word_merge.sv
  - cache_ctrl.sv
  - cache.sv
  - target: simulation
    files:
      - tb_clkgen.sv
      - cache_sva.sv
      - cache_tb.sv

//--- cache.sv
`timescale 1ns/1ps
`default_nettype none

module cache (
    input  logic                               clk,
    input  logic                               proc_reset,
    input  logic                               proc_read,
    input  logic                               proc_write,
    input  logic [cache_pkg::ADDR_W-1:0]       proc_addr,
    input  logic [cache_pkg::WORD_W-1:0]       proc_wdata,
    output logic [cache_pkg::WORD_W-1:0]       proc_rdata,
    output logic                               proc_stall,
    output logic                               mem_read,
    output logic                               mem_write,
    output logic [cache_pkg::BLOCK_ADDR_W-1:0] mem_addr,
    input  logic [cache_pkg::BLOCK_W-1:0]      mem_rdata,
    output logic [cache_pkg::BLOCK_W-1:0]      mem_wdata,
    input  logic                               mem_ready
);

    cache_pkg::cache_addr_u        addr;
    logic [cache_pkg::BLOCK_W-1:0] hit_block;
    logic [cache_pkg::BLOCK_W-1:0] merged_block;
    logic [cache_pkg::WORD_W-1:0]  word_out;
    logic                          use_mem;
    logic                          merge_en;

    assign addr = proc_addr;

    cache_lookup_if lk_if ();

    cache_ways ways_i (
        .clk        (clk),
        .proc_reset (proc_reset),
        .addr       (addr),
        .lk         (lk_if.ways),
        .hit_block  (hit_block)
    );

    cache_word_merge merge_i (
        .addr         (addr),
        .hit_block    (hit_block),
        .mem_rdata    (mem_rdata),
        .proc_wdata   (proc_wdata),
        .use_mem      (use_mem),
        .merge_en     (merge_en),
        .word_out     (word_out),
        .merged_block (merged_block)
    );

    cache_ctrl ctrl_i (
        .clk          (clk),
        .proc_reset   (proc_reset),
        .proc_read    (proc_read),
        .proc_write   (proc_write),
        .addr         (addr),
        .mem_ready    (mem_ready),
        .merged_block (merged_block),
        .word_out     (word_out),
        .lk           (lk_if.ctrl),
        .use_mem      (use_mem),
        .merge_en     (merge_en),
        .proc_stall   (proc_stall),
        .proc_rdata   (proc_rdata),
        .mem_read     (mem_read),
        .mem_write    (mem_write),
        .mem_addr     (mem_addr),
        .mem_wdata    (mem_wdata)
    );

endmodule

`default_nettype wire

//--- cache_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module cache_ctrl (
    input  logic                               clk,
    input  logic                               proc_reset,
    input  logic                               proc_read,
    input  logic                               proc_write,
    input  cache_pkg::cache_addr_u             addr,
    input  logic                               mem_ready,
    input  logic [cache_pkg::BLOCK_W-1:0]      merged_block,
    input  logic [cache_pkg::WORD_W-1:0]       word_out,
    cache_lookup_if.ctrl                       lk,
    output logic                               use_mem,
    output logic                               merge_en,
    output logic                               proc_stall,
    output logic [cache_pkg::WORD_W-1:0]       proc_rdata,
    output logic                               mem_read,
    output logic                               mem_write,
    output logic [cache_pkg::BLOCK_ADDR_W-1:0] mem_addr,
    output logic [cache_pkg::BLOCK_W-1:0]      mem_wdata
);

    localparam logic [1:0] S_IDLE    = 2'd0;
    localparam logic [1:0] S_RD_FILL = 2'd1;  // read miss, waiting for block
    localparam logic [1:0] S_WR_FILL = 2'd2;  // write miss, waiting for block
    localparam logic [1:0] S_WR_THRU = 2'd3;  // block write to memory

    logic [1:0]                         state_q, state_d;
    logic                               mem_read_q, mem_read_d;
    logic                               mem_write_q, mem_write_d;
    logic [cache_pkg::BLOCK_ADDR_W-1:0] mem_addr_q, mem_addr_d;
    logic [cache_pkg::BLOCK_W-1:0]      mem_wdata_q, mem_wdata_d;

    always_comb begin
        state_d     = state_q;
        mem_read_d  = mem_read_q;
        mem_write_d = mem_write_q;
        mem_addr_d  = mem_addr_q;
        mem_wdata_d = mem_wdata_q;
        use_mem     = 1'b0;
        merge_en    = 1'b0;
        proc_rdata  = '0;
        lk.wr_en    = 1'b0;
        lk.wr_way   = lk.victim_way;
        lk.wr_block = merged_block;

        case (state_q)
            S_IDLE: begin
                if (proc_write) begin
                    mem_addr_d = addr.blk.block_addr;
                    if (lk.hit) begin
                        merge_en    = 1'b1;  // patch the cached line
                        lk.wr_en    = 1'b1;
                        lk.wr_way   = lk.hit_way;
                        mem_write_d = 1'b1;
                        mem_wdata_d = merged_block;
                        state_d     = S_WR_THRU;
                    end else begin
                        mem_read_d = 1'b1;
                        state_d    = S_WR_FILL;
                    end
                end else if (proc_read) begin
                    if (lk.hit) begin
                        proc_rdata = word_out;
                    end else begin
                        mem_read_d = 1'b1;
                        mem_addr_d = addr.blk.block_addr;
                        state_d    = S_RD_FILL;
                    end
                end
            end
            S_RD_FILL: begin
                use_mem = 1'b1;
                if (mem_ready) begin
                    proc_rdata = word_out;  // straight from the memory block
                    lk.wr_en   = 1'b1;
                    mem_read_d = 1'b0;
                    state_d    = S_IDLE;
                end
            end
            S_WR_FILL: begin
                use_mem  = 1'b1;
                merge_en = 1'b1;
                if (mem_ready) begin
                    lk.wr_en    = 1'b1;  // store fill with new word merged in
                    mem_read_d  = 1'b0;
                    mem_write_d = 1'b1;
                    mem_wdata_d = merged_block;
                    state_d     = S_WR_THRU;
                end
            end
            default: begin
                if (mem_ready) begin
                    mem_write_d = 1'b0;
                    state_d     = S_IDLE;
                end
            end
        endcase
    end

    // stall holds until the FSM is heading back to idle
    assign proc_stall = (state_d != S_IDLE);

    always_ff @(posedge clk) begin
        if (proc_reset) begin
            state_q     <= S_IDLE;
            mem_read_q  <= 1'b0;
            mem_write_q <= 1'b0;
        end else begin
            state_q     <= state_d;
            mem_read_q  <= mem_read_d;
            mem_write_q <= mem_write_d;
        end
    end

    always_ff @(posedge clk) begin
        mem_addr_q  <= mem_addr_d;
        mem_wdata_q <= mem_wdata_d;
    end

    assign mem_read  = mem_read_q;
    assign mem_write = mem_write_q;
    assign mem_addr  = mem_addr_q;
    assign mem_wdata = mem_wdata_q;

endmodule

`default_nettype wire

//--- cache_lookup_if.sv
`timescale 1ns/1ps
`default_nettype none

interface cache_lookup_if;

    logic                          hit;         // tag match in indexed set
    logic                          hit_way;
    logic                          victim_way;  // way to refill on a miss

    logic                          wr_en;       // one-cycle line write strobe
    logic                          wr_way;
    logic [cache_pkg::BLOCK_W-1:0] wr_block;

    modport ways (
        output hit,
        output hit_way,
        output victim_way,
        input  wr_en,
        input  wr_way,
        input  wr_block
    );

    modport ctrl (
        input  hit,
        input  hit_way,
        input  victim_way,
        output wr_en,
        output wr_way,
        output wr_block
    );

endinterface

`default_nettype wire

//--- cache_pkg.sv
`default_nettype none

package cache_pkg;

    localparam int ADDR_W          = 30;    // processor word address
    localparam int WORD_W          = 32;
    localparam int WORDS_PER_BLOCK = 4;
    localparam int NUM_SETS        = 4;
    localparam int NUM_WAYS        = 2;

    localparam int BLOCK_W      = WORD_W * WORDS_PER_BLOCK;     // 128
    localparam int OFFSET_W     = $clog2(WORDS_PER_BLOCK);      // word in block
    localparam int INDEX_W      = $clog2(NUM_SETS);
    localparam int TAG_W        = ADDR_W - INDEX_W - OFFSET_W;  // 26
    localparam int BLOCK_ADDR_W = ADDR_W - OFFSET_W;            // memory side address

    // one processor address, seen either as cache fields or as a memory block address
    typedef union packed {
        struct packed {
            logic [TAG_W-1:0]    tag;
            logic [INDEX_W-1:0]  index;
            logic [OFFSET_W-1:0] offset;
        } fields;
        struct packed {
            logic [BLOCK_ADDR_W-1:0] block_addr;
            logic [OFFSET_W-1:0]     offset;
        } blk;
    } cache_addr_u;

endpackage

`default_nettype wire

//--- cache_sva.sv
`timescale 1ns/1ps
`default_nettype none

module cache_sva (
    input logic                               clk,
    input logic                               proc_reset,
    input logic                               proc_stall,
    input logic                               mem_read,
    input logic                               mem_write,
    input logic                               mem_ready,
    input logic [cache_pkg::BLOCK_ADDR_W-1:0] mem_addr
);

    int fail_cnt = 0;  // assertion failures so far

    a_one_transfer: assert property (@(posedge clk) disable iff (proc_reset)
        !(mem_read && mem_write))
        else begin
            fail_cnt++;
            $error("mem_read and mem_write high together");
        end

    // ready cycle releases the stall while the request is still registered
    a_stall_on_transfer: assert property (@(posedge clk) disable iff (proc_reset)
        (mem_read || mem_write) && !mem_ready |-> proc_stall)
        else begin
            fail_cnt++;
            $error("memory transfer open without proc_stall");
        end

    a_addr_held: assert property (@(posedge clk) disable iff (proc_reset)
        (mem_read || mem_write) && !mem_ready |=> $stable(mem_addr))
        else begin
            fail_cnt++;
            $error("mem_addr changed while a transfer waits");
        end

    a_idle_after_reset: assert property (@(posedge clk)
        $fell(proc_reset) |-> !mem_read && !mem_write)
        else begin
            fail_cnt++;
            $error("memory request active right after reset");
        end

endmodule

bind cache cache_sva sva_i (
    .clk        (clk),
    .proc_reset (proc_reset),
    .proc_stall (proc_stall),
    .mem_read   (mem_read),
    .mem_write  (mem_write),
    .mem_ready  (mem_ready),
    .mem_addr   (mem_addr)
);

`default_nettype wire

//--- cache_tb.sv
`timescale 1ns/1ps
`default_nettype none

module cache_tb;

    localparam int FIXED_OPS       = 14;
    localparam int RAND_OPS        = 40;
    localparam int NUM_OPS         = FIXED_OPS + RAND_OPS;
    localparam int CLK_PERIOD_NS   = 20;
    localparam int RESET_CYCLES    = 16;
    localparam int WATCHDOG_CYCLES = NUM_OPS * 2 * 6 + RESET_CYCLES;  // two transfers per op

    typedef struct {
        string                              name;
        bit                                 wr;
        cache_pkg::cache_addr_u             addr;
        logic [cache_pkg::WORD_W-1:0]       wdata;
        logic [cache_pkg::WORD_W-1:0]       rdata;    // proc_rdata at completion
        int                                 n_rd;     // memory transfers seen
        int                                 n_wr;
        logic [cache_pkg::BLOCK_ADDR_W-1:0] rd_addr;
        logic [cache_pkg::BLOCK_ADDR_W-1:0] wr_addr;
        logic [cache_pkg::BLOCK_W-1:0]      wr_data;
    } op_t;

    logic                               clk;
    logic                               proc_reset;
    logic                               proc_read;
    logic                               proc_write;
    logic [cache_pkg::ADDR_W-1:0]       proc_addr;
    logic [cache_pkg::WORD_W-1:0]       proc_wdata;
    logic [cache_pkg::WORD_W-1:0]       proc_rdata;
    logic                               proc_stall;
    logic                               mem_read;
    logic                               mem_write;
    logic [cache_pkg::BLOCK_ADDR_W-1:0] mem_addr;
    logic [cache_pkg::BLOCK_W-1:0]      mem_rdata = '0;
    logic [cache_pkg::BLOCK_W-1:0]      mem_wdata;
    logic                               mem_ready = 1'b0;

    op_t    ops [NUM_OPS];
    int     issued;     // ops finished on the processor side
    int     op_idx;     // op that memory transfers belong to
    int     errors;
    int     checks;
    integer seed = 3349;
    bit     pending;
    int     wait_cnt;

    logic [cache_pkg::BLOCK_W-1:0] mem_store [logic [cache_pkg::BLOCK_ADDR_W-1:0]];
    logic [cache_pkg::BLOCK_W-1:0] ref_mem   [logic [cache_pkg::BLOCK_ADDR_W-1:0]];
    bit                            ref_valid [cache_pkg::NUM_SETS][cache_pkg::NUM_WAYS];
    logic [cache_pkg::TAG_W-1:0]   ref_tag   [cache_pkg::NUM_SETS][cache_pkg::NUM_WAYS];
    bit                            ref_mru   [cache_pkg::NUM_SETS];

    tb_clkgen clkgen_i (.clk(clk));

    cache dut_i (.*);

    // untouched memory, every word tied to the whole block address
    function automatic logic [cache_pkg::BLOCK_W-1:0] block_pattern(
        input logic [cache_pkg::BLOCK_ADDR_W-1:0] ba
    );
        logic [cache_pkg::BLOCK_W-1:0] b;
        for (int i = 0; i < cache_pkg::WORDS_PER_BLOCK; i++) begin
            b[i*cache_pkg::WORD_W +: cache_pkg::WORD_W] = {i[1:0], 2'b10, ba};
        end
        return b;
    endfunction

    function automatic cache_pkg::cache_addr_u make_addr(input logic [cache_pkg::TAG_W-1:0] tag,
        input logic [cache_pkg::INDEX_W-1:0] index, input logic [cache_pkg::OFFSET_W-1:0] offset);
        cache_pkg::cache_addr_u a;
        a.fields.tag    = tag;
        a.fields.index  = index;
        a.fields.offset = offset;
        return a;
    endfunction

    // write-through keeps memory current, so words come from ref_mem alone
    function automatic void predict_access(input bit wr, input cache_pkg::cache_addr_u a,
        input logic [cache_pkg::WORD_W-1:0] wd, output bit miss,
        output logic [cache_pkg::WORD_W-1:0] word, output logic [cache_pkg::BLOCK_W-1:0] blk);
        int idx;
        int way;
        idx  = a.fields.index;
        miss = 1'b1;
        way  = 0;
        for (int w = 0; w < cache_pkg::NUM_WAYS; w++) begin
            if (ref_valid[idx][w] && ref_tag[idx][w] == a.fields.tag) begin
                miss = 1'b0;
                way  = w;
            end
        end
        if (miss) begin
            if (!ref_valid[idx][0]) begin
                way = 0;
            end else if (!ref_valid[idx][1]) begin
                way = 1;
            end else begin
                way = ref_mru[idx] ? 0 : 1;  // least recently touched
            end
        end
        blk  = ref_mem.exists(a.blk.block_addr) ? ref_mem[a.blk.block_addr]
                                                : block_pattern(a.blk.block_addr);
        word = blk[a.fields.offset*cache_pkg::WORD_W +: cache_pkg::WORD_W];
        if (wr) begin
            blk[a.fields.offset*cache_pkg::WORD_W +: cache_pkg::WORD_W] = wd;
            ref_mem[a.blk.block_addr] = blk;
        end
        if (wr || miss) begin  // read hits leave recency alone
            ref_valid[idx][way] = 1'b1;
            ref_tag[idx][way]   = a.fields.tag;
            ref_mru[idx]        = way[0];
        end
    endfunction

    function automatic void record_check(input string name, input bit bad, input string exp_s,
                                         input string act_s);
        checks++;
        if (bad) begin
            errors++;
            $display("FAIL %s: expected %s, actual %s", name, exp_s, act_s);
        end
    endfunction

    task automatic check_word(input string name, input logic [cache_pkg::WORD_W-1:0] exp, act);
        record_check(name, act !== exp, $sformatf("%h", exp), $sformatf("%h", act));
    endtask

    task automatic check_block(input string name, input logic [cache_pkg::BLOCK_W-1:0] exp, act);
        record_check(name, act !== exp, $sformatf("%h", exp), $sformatf("%h", act));
    endtask

    task automatic check_block_addr(input string name,
                                    input logic [cache_pkg::BLOCK_ADDR_W-1:0] exp, act);
        record_check(name, act !== exp, $sformatf("%h", exp), $sformatf("%h", act));
    endtask

    task automatic check_count(input string name, input int exp, act);
        record_check(name, act != exp, $sformatf("%0d", exp), $sformatf("%0d", act));
    endtask

    task automatic run_op(input string name, input bit wr, input cache_pkg::cache_addr_u addr,
                          input logic [cache_pkg::WORD_W-1:0] wdata);
        @(posedge clk);
        op_idx            = issued;
        ops[issued].name  = name;
        ops[issued].wr    = wr;
        ops[issued].addr  = addr;
        ops[issued].wdata = wdata;
        proc_read  <= !wr;
        proc_write <= wr;
        proc_addr  <= addr;
        proc_wdata <= wdata;
        @(negedge clk);
        while (proc_stall) begin
            @(negedge clk);
        end
        ops[issued].rdata = proc_rdata;  // request ends at the next edge
        issued++;
    endtask

    initial begin : stimulus
        integer rnd;
        proc_reset = 1'b1;
        proc_read  = 1'b0;
        proc_write = 1'b0;
        proc_addr  = '0;
        proc_wdata = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        proc_reset <= 1'b0;
        @(negedge clk);
        if (proc_stall !== 1'b0 || mem_read !== 1'b0 || mem_write !== 1'b0) begin
            errors++;
            $display("ERROR: proc_stall, mem_read or mem_write not low after reset");
        end
        run_op("rd_miss", 1'b0, make_addr(5, 1, 2), '0);
        run_op("rd_repeat_hit", 1'b0, make_addr(5, 1, 2), '0);
        run_op("wr_hit", 1'b1, make_addr(5, 1, 0), 32'hcafe_0001);
        run_op("rd_after_wr_hit", 1'b0, make_addr(5, 1, 0), '0);
        run_op("wr_miss", 1'b1, make_addr(7, 3, 1), 32'hbeef_0002);
        run_op("rd_after_wr_miss", 1'b0, make_addr(7, 3, 1), '0);
        // three tags fighting over set 2
        run_op("set2_wr_t10", 1'b1, make_addr(10, 2, 0), 32'h1111_0000);
        run_op("set2_rd_t11", 1'b0, make_addr(11, 2, 1), '0);
        run_op("set2_wr_t10_hit", 1'b1, make_addr(10, 2, 3), 32'h2222_0003);
        run_op("set2_rd_t12", 1'b0, make_addr(12, 2, 0), '0);
        run_op("set2_rd_t11_again", 1'b0, make_addr(11, 2, 2), '0);
        run_op("set2_rd_t12_hit", 1'b0, make_addr(12, 2, 1), '0);
        run_op("set2_rd_t10_again", 1'b0, make_addr(10, 2, 3), '0);
        run_op("set2_rd_t11_kept", 1'b0, make_addr(11, 2, 0), '0);
        for (int k = 0; k < RAND_OPS; k++) begin
            rnd = $random(seed);
            run_op($sformatf("rand_%0d", k), rnd[6], make_addr(rnd[1:0], rnd[3:2], rnd[5:4]),
                   $random(seed));
        end
        @(posedge clk);
        proc_read  <= 1'b0;
        proc_write <= 1'b0;
    end

    // block memory with 1 to 4 cycles of latency
    always @(posedge clk) begin : memory_model
        if (proc_reset) begin
            mem_ready <= 1'b0;
            pending = 1'b0;
        end else if (mem_ready) begin
            mem_ready <= 1'b0;  // one-cycle completion pulse
        end else if (mem_read || mem_write) begin
            if (!pending) begin
                pending  = 1'b1;
                wait_cnt = $unsigned($random(seed)) % 4;
            end
            if (wait_cnt == 0) begin
                pending = 1'b0;
                mem_ready <= 1'b1;
                if (mem_write) begin
                    mem_store[mem_addr] = mem_wdata;
                    ops[op_idx].n_wr++;
                    ops[op_idx].wr_addr = mem_addr;
                    ops[op_idx].wr_data = mem_wdata;
                end else begin
                    mem_rdata <= mem_store.exists(mem_addr) ? mem_store[mem_addr]
                                                            : block_pattern(mem_addr);
                    ops[op_idx].n_rd++;
                    ops[op_idx].rd_addr = mem_addr;
                end
            end else begin
                wait_cnt--;
            end
        end
    end

    initial begin : compare
        bit                            miss;
        logic [cache_pkg::WORD_W-1:0]  exp_word;
        logic [cache_pkg::BLOCK_W-1:0] exp_block;
        for (int n = 0; n < NUM_OPS; n++) begin
            wait (issued > n);
            predict_access(ops[n].wr, ops[n].addr, ops[n].wdata, miss, exp_word, exp_block);
            check_count({ops[n].name, " mem_read count"}, int'(miss), ops[n].n_rd);
            check_count({ops[n].name, " mem_write count"}, int'(ops[n].wr), ops[n].n_wr);
            if (miss) begin
                check_block_addr({ops[n].name, " read mem_addr"},
                                 ops[n].addr.blk.block_addr, ops[n].rd_addr);
            end
            if (ops[n].wr) begin
                check_block_addr({ops[n].name, " write mem_addr"},
                                 ops[n].addr.blk.block_addr, ops[n].wr_addr);
                check_block({ops[n].name, " mem_wdata"}, exp_block, ops[n].wr_data);
            end else begin
                check_word({ops[n].name, " proc_rdata"}, exp_word, ops[n].rdata);
            end
        end
        @(posedge clk);
        errors += dut_i.sva_i.fail_cnt;  // protocol assertions count as errors too
        $display("checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

    initial begin : watchdog
        #(WATCHDOG_CYCLES * CLK_PERIOD_NS);
        $display("ERROR: timed out after %0d cycles with operations still open", WATCHDOG_CYCLES);
        $display("CHECKS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- cache_ways.sv
`timescale 1ns/1ps
`default_nettype none

module cache_ways (
    input  logic                          clk,
    input  logic                          proc_reset,
    input  cache_pkg::cache_addr_u        addr,
    cache_lookup_if.ways                  lk,
    output logic [cache_pkg::BLOCK_W-1:0] hit_block
);

    logic                          valid_q [cache_pkg::NUM_SETS][cache_pkg::NUM_WAYS];
    logic [cache_pkg::TAG_W-1:0]   tag_q   [cache_pkg::NUM_SETS][cache_pkg::NUM_WAYS];
    logic [cache_pkg::BLOCK_W-1:0] data_q  [cache_pkg::NUM_SETS][cache_pkg::NUM_WAYS];
    logic                          mru_q   [cache_pkg::NUM_SETS];  // way touched last

    logic [cache_pkg::INDEX_W-1:0]  set_idx;
    logic [cache_pkg::NUM_WAYS-1:0] way_hit;
    logic                           hit_way;

    assign set_idx = addr.fields.index;

    // tag compare across both ways of the set
    always_comb begin
        for (int w = 0; w < cache_pkg::NUM_WAYS; w++) begin
            way_hit[w] = valid_q[set_idx][w] && (tag_q[set_idx][w] == addr.fields.tag);
        end
    end

    assign hit_way    = way_hit[1];  // a tag lives in one way only
    assign lk.hit     = |way_hit;
    assign lk.hit_way = hit_way;
    assign hit_block  = data_q[set_idx][hit_way];

    // empty ways are taken first, then the one not used last
    always_comb begin
        if (!valid_q[set_idx][0]) begin
            lk.victim_way = 1'b0;
        end else if (!valid_q[set_idx][1]) begin
            lk.victim_way = 1'b1;
        end else begin
            lk.victim_way = ~mru_q[set_idx];
        end
    end

    always_ff @(posedge clk) begin
        if (proc_reset) begin
            for (int s = 0; s < cache_pkg::NUM_SETS; s++) begin
                mru_q[s] <= 1'b0;
                for (int w = 0; w < cache_pkg::NUM_WAYS; w++) begin
                    valid_q[s][w] <= 1'b0;
                    tag_q[s][w]   <= '0;
                    data_q[s][w]  <= '0;
                end
            end
        end else if (lk.wr_en) begin
            valid_q[set_idx][lk.wr_way] <= 1'b1;
            tag_q[set_idx][lk.wr_way]   <= addr.fields.tag;
            data_q[set_idx][lk.wr_way]  <= lk.wr_block;
            mru_q[set_idx]              <= lk.wr_way;  // fills and writes only
        end
    end

endmodule

`default_nettype wire

//--- cache_word_merge.sv
`timescale 1ns/1ps
`default_nettype none

module cache_word_merge (
    input  cache_pkg::cache_addr_u        addr,
    input  logic [cache_pkg::BLOCK_W-1:0] hit_block,
    input  logic [cache_pkg::BLOCK_W-1:0] mem_rdata,
    input  logic [cache_pkg::WORD_W-1:0]  proc_wdata,
    input  logic                          use_mem,
    input  logic                          merge_en,
    output logic [cache_pkg::WORD_W-1:0]  word_out,
    output logic [cache_pkg::BLOCK_W-1:0] merged_block
);

    logic [cache_pkg::BLOCK_W-1:0]  src_block;
    logic [cache_pkg::OFFSET_W-1:0] offset;

    assign offset    = addr.fields.offset;
    assign src_block = use_mem ? mem_rdata : hit_block;  // refill data or cached line

    // word i sits at bits 32i+31 down to 32i
    always_comb begin
        word_out = '0;
        for (int i = 0; i < cache_pkg::WORDS_PER_BLOCK; i++) begin
            if (offset == i) begin
                word_out = src_block[i*cache_pkg::WORD_W +: cache_pkg::WORD_W];
            end
        end
    end

    always_comb begin
        for (int i = 0; i < cache_pkg::WORDS_PER_BLOCK; i++) begin
            if (merge_en && (offset == i)) begin
                merged_block[i*cache_pkg::WORD_W +: cache_pkg::WORD_W] = proc_wdata;
            end else begin
                merged_block[i*cache_pkg::WORD_W +: cache_pkg::WORD_W] =
                    src_block[i*cache_pkg::WORD_W +: cache_pkg::WORD_W];
            end
        end
    end

endmodule

`default_nettype wire

//--- sim.f
cache_pkg.sv
cache_lookup_if.sv
cache_ways.sv
cache_word_merge.sv
cache_ctrl.sv
cache.sv
tb_clkgen.sv
cache_sva.sv
cache_tb.sv

//--- tb_clkgen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clkgen (
    output logic clk
);

    localparam int HALF_PERIOD_NS = 10;  // 20 ns period

    initial begin
        clk = 1'b0;
        forever begin
            #HALF_PERIOD_NS clk = ~clk;
        end
    end

endmodule

`default_nettype wire
